// ==== build.f ====
rtl/csa_pkg.sv
rtl/csa_queue.sv
rtl/csa_calc_core.sv
rtl/csa_calc_wrap.sv
tb/csa_clk_gen.sv
tb/csa_calc_assert.sv
tb/csa_calc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the csa calc testbench with Verilator
# the exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert \
	--top-module csa_calc_tb \
	--Mdir obj_dir \
	-o csa_calc_sim \
	-f build.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/csa_calc_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0

// ==== tb/csa_calc_tb.sv ====
`timescale 1ns/1ps

module csa_calc_tb;

	localparam int in_depth   = 16;
	localparam int out_depth  = 4;
	localparam int drive_ns   = 2;
	localparam int max_rounds = 20;
	localparam int n_zero     = 4;
	localparam int n_random   = 40;
	localparam int fill_limit = in_depth + out_depth + 1;
	localparam int n_dropped  = 3;
	localparam int idle_wait  = 2 * (max_rounds + 10);
	localparam int total_req  = 2 + n_zero + n_random + fill_limit + n_dropped + 4;
	localparam int timeout_cycles = total_req * (max_rounds + 10) + idle_wait;
	localparam int unsigned seed  = 32'hd817_b1de;

	logic               clk;
	logic               rst_n;
	logic               csa_in_wen;
	csa_pkg::csa_req_t  csa_in;
	logic               csa_in_full;
	logic               csa_out_ready;
	logic               csa_out_ren;
	csa_pkg::csa_resp_t csa_out;

	csa_pkg::csa_resp_t sb[$];  // expected results in write order
	logic [31:0]        next_tag;

	csa_clk_gen #(.period_ns(40), .reset_cycles(5), .drive_ns(drive_ns)) u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	csa_calc_wrap #(.in_depth(in_depth), .out_depth(out_depth)) dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.csa_in_wen_i    (csa_in_wen),
		.csa_in_i        (csa_in),
		.csa_in_full_o   (csa_in_full),
		.csa_out_ready_o (csa_out_ready),
		.csa_out_ren_i   (csa_out_ren),
		.csa_out_o       (csa_out)
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// rotate left a byte, xor the index byte into every lane, fold low half into high half
	function automatic logic [63:0] apply_rounds(input logic [63:0] v, input logic [31:0] first,
		input logic [31:0] n);
		logic [63:0] s;
		logic [31:0] r;
		logic [31:0] sum;
		s = v;
		r = first;
		for (int unsigned k = 0; k < n; k++) begin
			s = (s << 8) | (s >> 56);
			s = s ^ (64'h0101_0101_0101_0101 * r[7:0]);
			sum = s[63:32] + s[31:0];
			s = {sum, s[31:0]};
			r = r + 32'd1;
		end
		return s;
	endfunction

	function automatic csa_pkg::csa_resp_t expect_resp(input csa_pkg::csa_req_t req);
		csa_pkg::csa_resp_t resp;
		resp.block       = req.block;
		resp.calc_in     = req.calc_in;
		resp.times       = req.times;
		resp.times_start = req.times_start;
		resp.calc_out    = apply_rounds(req.calc_in, req.times_start, req.times);
		return resp;
	endfunction

	task automatic make_req(input logic [31:0] rounds, output csa_pkg::csa_req_t req);
		req.block       = next_tag;
		req.calc_in     = {$urandom(), $urandom()};
		req.times       = rounds;
		req.times_start = $urandom();
		next_tag = next_tag + 32'd1;
	endtask

	// one write cycle, called at the drive point, returns at the next drive point
	task automatic push_request(input csa_pkg::csa_req_t req, output bit accepted);
		accepted = !csa_in_full;
		csa_in_wen = 1'b1;
		csa_in = req;
		@(posedge clk);
		#drive_ns;
		csa_in_wen = 1'b0;
		if (accepted) sb.push_back(expect_resp(req));
	endtask

	task automatic pop_result();
		csa_pkg::csa_resp_t exp;
		while (!csa_out_ready) begin
			@(posedge clk);
			#drive_ns;
		end
		assert (sb.size() != 0) else fail_run("result appeared with no request outstanding");
		exp = sb.pop_front();
		check_val("csa_out_o.block", 64'(exp.block), 64'(csa_out.block));
		check_val("csa_out_o.calc_in", exp.calc_in, csa_out.calc_in);
		check_val("csa_out_o.times", 64'(exp.times), 64'(csa_out.times));
		check_val("csa_out_o.times_start", 64'(exp.times_start), 64'(csa_out.times_start));
		check_val("csa_out_o.calc_out", exp.calc_out, csa_out.calc_out);
		csa_out_ren = 1'b1;
		@(posedge clk);
		#drive_ns;
		csa_out_ren = 1'b0;
	endtask

	task automatic drain_all();
		while (sb.size() != 0) pop_result();
	endtask

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, DUT stopped responding", timeout_cycles);
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		csa_pkg::csa_req_t req;
		bit                ok;
		int                n;
		int                accepted_cnt;
		logic [31:0]       rounds;
		csa_in_wen  = 1'b0;
		csa_in      = '0;
		csa_out_ren = 1'b0;
		next_tag    = 32'h0000_0100;
		void'($urandom(seed));
		wait (rst_n === 1'b1);

		// latency into an idle system, zero rounds and then some rounds
		for (int i = 0; i < 2; i++) begin
			rounds = (i == 0) ? 32'd0 : $urandom_range(max_rounds, 1);
			make_req(rounds, req);
			push_request(req, ok);
			n = 1;
			while (!csa_out_ready && n < idle_wait) begin
				@(posedge clk);
				#drive_ns;
				n++;
			end
			check_val("csa_out_ready_o latency", 64'(4 + rounds), 64'(n));
			pop_result();
		end

		for (int i = 0; i < n_zero; i++) begin
			make_req(32'd0, req);
			push_request(req, ok);
		end
		drain_all();

		// random traffic with reads mixed in
		for (int i = 0; i < n_random; i++) begin
			while (csa_in_full) begin
				if (csa_out_ready) begin
					pop_result(); // a full output queue would stall the core for good
				end else begin
					@(posedge clk);
					#drive_ns;
				end
			end
			make_req($urandom_range(max_rounds, 0), req);
			push_request(req, ok);
			if ($urandom_range(1, 0) == 1 && csa_out_ready) pop_result();
		end
		drain_all();

		// back-pressure, no reads until the input queue reports full
		accepted_cnt = 0;
		while (!csa_in_full && accepted_cnt <= fill_limit) begin
			make_req($urandom_range(max_rounds, 0), req);
			push_request(req, ok);
			if (ok) accepted_cnt++;
		end
		assert (csa_in_full && accepted_cnt <= fill_limit)
			else fail_run("csa_in_full_o did not rise within the allowed accepted writes");
		// top up until both queues and the core are occupied, full then stays high
		while (accepted_cnt < fill_limit) begin
			make_req($urandom_range(max_rounds, 0), req);
			push_request(req, ok);
			if (ok) accepted_cnt++;
		end
		for (int i = 0; i < n_dropped; i++) begin
			make_req(32'd1, req);
			push_request(req, ok);
		end
		drain_all();
		repeat (idle_wait) @(posedge clk);
		#drive_ns;
		check_val("csa_out_ready_o", 64'd0, 64'(csa_out_ready));

		$display("Test passed");
		$finish;
	end

endmodule

// ==== tb/csa_calc_assert.sv ====
`timescale 1ns/1ps

module csa_calc_assert (
	input logic               clk,
	input logic               rst_n,
	input logic               csa_in_wen_i,
	input logic               csa_in_full_o,
	input logic               csa_out_ready_o,
	input logic               csa_out_ren_i,
	input csa_pkg::csa_resp_t csa_out_o
);

	// both flags clear in every cycle that follows a reset edge
	reset_flags_low: assert property (
		@(posedge clk) !rst_n |=> (!csa_out_ready_o && !csa_in_full_o)
	) else $error("csa_out_ready_o or csa_in_full_o high after a reset cycle");

	// show-ahead head must not move until it is popped
	head_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(csa_out_ready_o && !csa_out_ren_i) |=> $stable(csa_out_o)
	) else $error("csa_out_o changed while ready and not read");

	head_kept: assert property (
		@(posedge clk) disable iff (!rst_n)
		(csa_out_ready_o && !csa_out_ren_i) |=> csa_out_ready_o
	) else $error("csa_out_ready_o dropped without a read");

	// input queue only fills through a host write
	full_after_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(csa_in_full_o) |-> $past(csa_in_wen_i)
	) else $error("csa_in_full_o rose without a write in the cycle before");

	flags_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown({csa_out_ready_o, csa_in_full_o})
	) else $error("csa_out_ready_o or csa_in_full_o unknown after reset");

endmodule

bind csa_calc_wrap csa_calc_assert u_assert (
	.clk             (clk),
	.rst_n           (rst_n),
	.csa_in_wen_i    (csa_in_wen_i),
	.csa_in_full_o   (csa_in_full_o),
	.csa_out_ready_o (csa_out_ready_o),
	.csa_out_ren_i   (csa_out_ren_i),
	.csa_out_o       (csa_out_o)
);

// ==== tb/csa_clk_gen.sv ====
`timescale 1ns/1ps

module csa_clk_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 5,
	parameter int drive_ns     = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#drive_ns rst_n = 1'b1; // released off the edge like all other stimulus
	end

endmodule

// ==== rtl/csa_calc_wrap.sv ====
`timescale 1ns/1ps

module csa_calc_wrap #(
	parameter int in_depth  = 16,
	parameter int out_depth = 4
) (
	input  logic               clk,
	input  logic               rst_n,

	// request side
	input  logic               csa_in_wen_i,
	input  csa_pkg::csa_req_t  csa_in_i,
	output logic               csa_in_full_o,

	// result side
	output logic               csa_out_ready_o,
	input  logic               csa_out_ren_i,
	output csa_pkg::csa_resp_t csa_out_o
);

	logic               req_ready;
	logic               req_pop;
	csa_pkg::csa_req_t  req_head;

	logic               resp_push;
	logic               resp_full;
	csa_pkg::csa_resp_t resp;

	// request queue, several items wait here while the core runs
	csa_queue #(
		.width (csa_pkg::req_w),
		.depth (in_depth)
	) u_in_q (
		.clk     (clk),
		.rst_n   (rst_n),
		.wen_i   (csa_in_wen_i),
		.wdata_i (csa_in_i),
		.ren_i   (req_pop),
		.rdata_o (req_head),
		.ready_o (req_ready),
		.full_o  (csa_in_full_o)
	);

	csa_calc_core u_calc (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_ready_i (req_ready),
		.req_i       (req_head),
		.req_pop_o   (req_pop),
		.resp_full_i (resp_full),
		.resp_push_o (resp_push),
		.resp_o      (resp)
	);

	// result queue, full stalls the core in st_emit
	csa_queue #(
		.width (csa_pkg::resp_w),
		.depth (out_depth)
	) u_out_q (
		.clk     (clk),
		.rst_n   (rst_n),
		.wen_i   (resp_push),
		.wdata_i (resp),
		.ren_i   (csa_out_ren_i),
		.rdata_o (csa_out_o),
		.ready_o (csa_out_ready_o),
		.full_o  (resp_full)
	);

endmodule

// ==== rtl/csa_calc_core.sv ====
`timescale 1ns/1ps

module csa_calc_core (
	input  logic               clk,
	input  logic               rst_n,

	// input queue side
	input  logic               req_ready_i,
	input  csa_pkg::csa_req_t  req_i,
	output logic               req_pop_o,

	// output queue side
	input  logic               resp_full_i,
	output logic               resp_push_o,
	output csa_pkg::csa_resp_t resp_o
);

	localparam int half_w  = csa_pkg::calc_w / 2;
	localparam int lanes   = csa_pkg::calc_w / csa_pkg::rot_w;

	csa_pkg::core_state_e state_q;
	csa_pkg::core_state_e state_d;

	csa_pkg::csa_req_t req_q;                     // request being worked on

	logic [csa_pkg::calc_w-1:0] work_q;           // working state
	logic [csa_pkg::data_w-1:0] cnt_q;            // rounds left
	logic [csa_pkg::data_w-1:0] idx_q;            // current round index

	// one reduced mixing round at index r
	function automatic logic [csa_pkg::calc_w-1:0] mix_round(
		input logic [csa_pkg::calc_w-1:0] s,
		input logic [csa_pkg::data_w-1:0] r
	);
		logic [csa_pkg::calc_w-1:0] rot;
		logic [csa_pkg::calc_w-1:0] x;
		logic [half_w-1:0]          hi;
		rot = {s[csa_pkg::calc_w-csa_pkg::rot_w-1:0],
			s[csa_pkg::calc_w-1 -: csa_pkg::rot_w]};   // rotate left one byte
		x = rot ^ {lanes{r[csa_pkg::rot_w-1:0]}};      // low byte of r in every lane
		hi = x[csa_pkg::calc_w-1 -: half_w] + x[half_w-1:0]; // mod 2^32
		return {hi, x[half_w-1:0]};
	endfunction

	assign req_pop_o   = (state_q == csa_pkg::st_idle) & req_ready_i;
	assign resp_push_o = (state_q == csa_pkg::st_emit) & ~resp_full_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			csa_pkg::st_idle: begin
				if (req_ready_i) begin
					state_d = csa_pkg::st_load;
				end
			end
			csa_pkg::st_load: begin
				if (req_q.times == '0) begin
					state_d = csa_pkg::st_emit; // zero rounds skip st_run
				end else begin
					state_d = csa_pkg::st_run;
				end
			end
			csa_pkg::st_run: begin
				if (cnt_q == 1) begin
					state_d = csa_pkg::st_emit;
				end
			end
			csa_pkg::st_emit: begin
				if (!resp_full_i) begin
					state_d = csa_pkg::st_idle;
				end
			end
			default: state_d = csa_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= csa_pkg::st_idle;
			cnt_q   <= '0;
			idx_q   <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == csa_pkg::st_load) begin
				cnt_q <= req_q.times;
				idx_q <= req_q.times_start;
			end else if (state_q == csa_pkg::st_run) begin
				cnt_q <= cnt_q - 1'b1;
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (req_pop_o) begin
			req_q <= req_i;
		end
		if (state_q == csa_pkg::st_load) begin
			work_q <= req_q.calc_in;
		end else if (state_q == csa_pkg::st_run) begin
			work_q <= mix_round(work_q, idx_q);
		end
	end

	always_comb begin
		resp_o.block       = req_q.block;
		resp_o.calc_in     = req_q.calc_in;
		resp_o.times       = req_q.times;
		resp_o.times_start = req_q.times_start;
		resp_o.calc_out    = work_q;
	end

endmodule

// ==== rtl/csa_queue.sv ====
`timescale 1ns/1ps

module csa_queue #(
	parameter int width = 32,
	parameter int depth = 16
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             wen_i,
	input  logic [width-1:0] wdata_i,

	input  logic             ren_i,
	output logic [width-1:0] rdata_o,

	output logic             ready_o,
	output logic             full_o
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	localparam logic [ptr_w-1:0] last_ptr  = ptr_w'(depth - 1);
	localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(depth);

	logic [width-1:0] mem [depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	logic do_push;
	logic do_pop;

	assign full_o  = (count == depth_cnt);
	assign ready_o = (count != '0);

	assign do_push = wen_i & ~full_o;   // push while full is dropped
	assign do_pop  = ren_i & ready_o;   // pop while empty is ignored

	// show-ahead, head is visible without a read cycle
	assign rdata_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1; // wrap for any depth
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;       // both or neither
			endcase
		end
	end

endmodule

// ==== rtl/csa_pkg.sv ====
package csa_pkg;

	// host word, also used for tag, round count and round index
	localparam int data_w = 32;

	// calculation value
	localparam int calc_w = 64;

	// byte lane of the round rule: rotate amount and xor pattern unit
	localparam int rot_w = 8;

	// request record, block tag in the lowest host word
	typedef struct packed {
		logic [data_w-1:0] times_start; // first round index
		logic [data_w-1:0] times;       // round count
		logic [calc_w-1:0] calc_in;     // two host words
		logic [data_w-1:0] block;       // tag, returned as is
	} csa_req_t;

	// response record, request fields echoed below the result
	typedef struct packed {
		logic [calc_w-1:0] calc_out;    // final state
		logic [data_w-1:0] times_start;
		logic [data_w-1:0] times;
		logic [calc_w-1:0] calc_in;
		logic [data_w-1:0] block;
	} csa_resp_t;

	// five and seven host words
	localparam int req_w  = $bits(csa_req_t);
	localparam int resp_w = $bits(csa_resp_t);

	// calc core sequence
	typedef enum logic [1:0] {
		st_idle,  // wait for a queued request
		st_load,  // copy calc_in into the working state
		st_run,   // one round per cycle
		st_emit   // wait for room in the output queue
	} core_state_e;

endpackage
